// ==== Makefile ====
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv32_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
hdl/rv32_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/core_control.sv
hdl/rv32_core.sv
testbench/tb_rv32_core.sv

// ==== hdl/alu.sv ====
// Combinational RV32I execute unit, decodes the instruction word itself
// Gives the write-back value, the load/store address and the branch decision
// Results for opcodes outside the base set are don't-care
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  rv32_pkg::instr_word_t       instr,
	input  logic [rv32_pkg::xlen-1:0]   pc,
	input  logic [rv32_pkg::xlen-1:0]   rs1_data,
	input  logic [rv32_pkg::xlen-1:0]   rs2_data,
	output logic [rv32_pkg::xlen-1:0]   alu_result,
	output logic [rv32_pkg::xlen-1:0]   mem_address,
	output logic                        branch_taken
);
	import rv32_pkg::*;

	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] operand_b;
	logic [4:0]      shamt;
	logic            is_sub;
	logic [xlen-1:0] arith;

	assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
	assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
	assign imm_u = {instr.u.imm, 12'h000};
	assign operand_b = (instr.r.opcode == op_reg) ? rs2_data : imm_i;
	assign shamt = operand_b[4:0];
	// ADDI has no SUB form, bit 30 is just immediate there
	assign is_sub = instr.r.funct7[5] && (instr.r.opcode == op_reg);

	always_comb
	begin
		case (instr.r.funct3)
			f3_add:  arith = is_sub ? rs1_data - operand_b : rs1_data + operand_b;
			f3_sll:  arith = rs1_data << shamt;
			f3_slt:  arith = {{(xlen-1){1'b0}}, $signed(rs1_data) < $signed(operand_b)};
			f3_sltu: arith = {{(xlen-1){1'b0}}, rs1_data < operand_b};
			f3_xor:  arith = rs1_data ^ operand_b;
			f3_sr:   arith = instr.r.funct7[5] ? $unsigned($signed(rs1_data) >>> shamt)
			                                   : rs1_data >> shamt;
			f3_or:   arith = rs1_data | operand_b;
			default: arith = rs1_data & operand_b;   // f3_and
		endcase
	end

	always_comb
	begin
		case (instr.r.opcode)
			op_lui:          alu_result = imm_u;
			op_auipc:        alu_result = pc + imm_u;
			op_jal, op_jalr: alu_result = pc + 32'd4;   // Link value
			default:         alu_result = arith;
		endcase
	end

	assign mem_address = rs1_data + ((instr.r.opcode == op_store) ? imm_s : imm_i);

	always_comb
	begin
		branch_taken = 1'b0;
		if (instr.b.opcode == op_branch)
		begin
			case (instr.b.funct3)
				f3_beq:  branch_taken = (rs1_data == rs2_data);
				f3_bne:  branch_taken = (rs1_data != rs2_data);
				f3_blt:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
				f3_bge:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
				f3_bltu: branch_taken = (rs1_data < rs2_data);
				f3_bgeu: branch_taken = (rs1_data >= rs2_data);
				default: branch_taken = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/core_control.sv ====
// Bus and instruction sequencer for the RV32I core
// Never more than one access in flight; req rises again only after ack is seen low
// Every load is treated as LW and every store as SW
// Unknown opcodes pass through execute as no-ops
`timescale 1ns/1ps
`default_nettype none

module core_control #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
)(
	input  logic                        clk,
	input  logic                        rst,
	output logic                        mem_req,
	output logic                        mem_we,
	output logic [rv32_pkg::xlen-1:0]   mem_addr,
	output logic [rv32_pkg::xlen-1:0]   mem_wdata,
	input  logic                        mem_ack,
	input  logic [rv32_pkg::xlen-1:0]   mem_rdata,
	input  logic [rv32_pkg::xlen-1:0]   pc,
	input  logic [rv32_pkg::xlen-1:0]   alu_result,
	input  logic [rv32_pkg::xlen-1:0]   mem_address,
	input  logic [rv32_pkg::xlen-1:0]   rs2_data,
	output rv32_pkg::instr_word_t       instr,
	output logic                        reg_we,
	output logic [rv32_pkg::xlen-1:0]   wr_data,
	output logic                        pc_update
);
	import rv32_pkg::*;

	localparam logic [2:0] fetch_req      = 3'd0;
	localparam logic [2:0] fetch_wait_low = 3'd1;
	localparam logic [2:0] execute        = 3'd2;
	localparam logic [2:0] data_req       = 3'd3;
	localparam logic [2:0] data_wait_low  = 3'd4;
	localparam logic [2:0] load_write     = 3'd5;

	// LUI into x0 carrying the upper vector bits, harmless if it retires
	localparam logic [31:0] boot_word = {RESET_VECTOR[31:12], 5'd0, op_lui};

	logic [2:0]      state;
	logic [xlen-1:0] load_data;
	logic            is_load;
	logic            is_store;
	logic            writes_rd;

	assign is_load = (instr.r.opcode == op_load);
	assign is_store = (instr.r.opcode == op_store);

	always_comb
	begin
		case (instr.r.opcode)
			op_lui, op_auipc, op_jal, op_jalr, op_imm, op_reg, op_load:
				writes_rd = (instr.r.rd != 5'd0);   // x0 writes dropped here
			default:
				writes_rd = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= load_write;   // Exit path that leaves pc alone
			instr <= boot_word;
		end
		else
		begin
			case (state)
				fetch_req:
				begin
					if (mem_ack)
					begin
						instr <= mem_rdata;   // Captured on the first ack edge
						state <= fetch_wait_low;
					end
				end
				fetch_wait_low:
				begin
					if (!mem_ack)
						state <= execute;
				end
				execute:
				begin
					if (is_load || is_store)
						state <= data_req;
					else
						state <= fetch_req;
				end
				data_req:
				begin
					if (mem_ack)
						state <= data_wait_low;
				end
				data_wait_low:
				begin
					if (!mem_ack)
						state <= is_load ? load_write : fetch_req;
				end
				default:
					state <= fetch_req;   // load_write and unused codes
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == data_req && mem_ack && is_load)
			load_data <= mem_rdata;
	end

	assign mem_req = (state == fetch_req) || (state == data_req);
	assign mem_we = (state == data_req) && is_store;
	assign mem_addr = (state == data_req) ? {mem_address[xlen-1:2], 2'b00}
	                                      : {pc[xlen-1:2], 2'b00};
	assign mem_wdata = rs2_data;

	assign wr_data = (state == load_write) ? load_data : alu_result;
	assign reg_we = writes_rd && (((state == execute) && !is_load) || (state == load_write));
	// Stores hold pc until their data handshake has fully closed
	assign pc_update = ((state == execute) && !is_store)
	                || ((state == data_wait_low) && is_store && !mem_ack);

endmodule

`default_nettype wire

// ==== hdl/pc_unit.sv ====
// Program counter and next-PC select for the RV32I core
// pc only moves on the edge after a pc_update strobe
// Targets are not checked for alignment
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
)(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        pc_update,
	input  rv32_pkg::instr_word_t       instr,
	input  logic [rv32_pkg::xlen-1:0]   rs1_data,
	input  logic                        branch_taken,
	output logic [rv32_pkg::xlen-1:0]   pc
);
	import rv32_pkg::*;

	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_j;
	logic [xlen-1:0] jalr_sum;
	logic [xlen-1:0] pc_next;

	assign pc_plus4 = pc + 32'd4;
	assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
	                instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
	assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
	                instr.j.imm_11, instr.j.imm_10_1, 1'b0};
	assign jalr_sum = rs1_data + {{20{instr.i.imm[11]}}, instr.i.imm};

	always_comb
	begin
		case (instr.r.opcode)
			op_jal:    pc_next = pc + imm_j;
			op_jalr:   pc_next = {jalr_sum[xlen-1:1], 1'b0};   // Bit 0 cleared
			op_branch: pc_next = branch_taken ? pc + imm_b : pc_plus4;
			default:   pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= RESET_VECTOR;
		else if (pc_update)
			pc <= pc_next;
	end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
// RV32I register file, x1 to x31 plus a hard-wired zero x0
// Two combinational read ports, one write port on the rising edge
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [rv32_pkg::reg_addr_w-1:0]   rs1_addr,
	input  logic [rv32_pkg::reg_addr_w-1:0]   rs2_addr,
	input  logic [rv32_pkg::reg_addr_w-1:0]   rd_addr,
	input  logic                              reg_we,
	input  logic [rv32_pkg::xlen-1:0]         wr_data,
	output logic [rv32_pkg::xlen-1:0]         rs1_data,
	output logic [rv32_pkg::xlen-1:0]         rs2_data
);
	import rv32_pkg::*;

	logic [xlen-1:0] regs [1:31];   // No storage behind x0

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int k = 1; k < 32; k++)
				regs[k] <= '0;
		end
		else if (reg_we && (rd_addr != '0))
			regs[rd_addr] <= wr_data;
	end

	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== hdl/rv32_core.sv ====
// RV32I core top level on a single shared memory bus
// Four-phase req/ack handshake, one access at a time; ack may be delayed freely
// Word accesses only, mem_addr[1:0] always reads zero
// Each instruction takes one fetch handshake plus one execute cycle,
// LW and SW add a second handshake
`timescale 1ns/1ps
`default_nettype none

module rv32_core #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
)(
	input  logic                        clk,
	input  logic                        rst,
	output logic                        mem_req,
	output logic                        mem_we,
	output logic [rv32_pkg::xlen-1:0]   mem_addr,
	output logic [rv32_pkg::xlen-1:0]   mem_wdata,
	input  logic                        mem_ack,
	input  logic [rv32_pkg::xlen-1:0]   mem_rdata
);
	import rv32_pkg::*;

	instr_word_t     instr;
	logic            reg_we;
	logic [xlen-1:0] wr_data;
	logic            pc_update;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] mem_address;
	logic            branch_taken;

	core_control #(
		.RESET_VECTOR(RESET_VECTOR)
	) core_control_inst (
		.clk         (clk),
		.rst         (rst),
		.mem_req     (mem_req),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata),
		.pc          (pc),
		.alu_result  (alu_result),
		.mem_address (mem_address),
		.rs2_data    (rs2_data),
		.instr       (instr),
		.reg_we      (reg_we),
		.wr_data     (wr_data),
		.pc_update   (pc_update)
	);

	reg_file reg_file_inst (
		.clk      (clk),
		.rst      (rst),
		.rs1_addr (instr.r.rs1),
		.rs2_addr (instr.r.rs2),
		.rd_addr  (instr.r.rd),
		.reg_we   (reg_we),
		.wr_data  (wr_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	alu alu_inst (
		.instr        (instr),
		.pc           (pc),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.alu_result   (alu_result),
		.mem_address  (mem_address),
		.branch_taken (branch_taken)
	);

	pc_unit #(
		.RESET_VECTOR(RESET_VECTOR)
	) pc_unit_inst (
		.clk          (clk),
		.rst          (rst),
		.pc_update    (pc_update),
		.instr        (instr),
		.rs1_data     (rs1_data),
		.branch_taken (branch_taken),
		.pc           (pc)
	);

endmodule

`default_nettype wire

// ==== hdl/rv32_pkg.sv ====
// Shared widths, opcodes and funct3 codes for the RV32I core
// Base integer subset only; there are no C or M extension codes here
// The instruction word is one 32-bit packed union read in six formats
`default_nettype none

package rv32_pkg;

	localparam int xlen = 32;        // Data and address width
	localparam int reg_addr_w = 5;   // Register index width

	// Major opcodes, instruction bits [6:0]
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;

	localparam logic [2:0] f3_beq  = 3'b000;   // Branch compares
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	localparam logic [2:0] f3_add  = 3'b000;   // ADD, SUB, ADDI
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;   // SRL or SRA by funct7[5]
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// opcode, rd, rs1 and rs2 sit at the same bits in every format
	typedef union packed
	{
		struct packed
		{
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed
		{
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed
		{
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		struct packed
		{
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b;
		struct packed
		{
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed
		{
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} instr_word_t;

endpackage

`default_nettype wire

// ==== testbench/program_patterns.hex ====
// Words 0x000 on: program image at address 0, several instruction words per line
// Words 0x100 on: store records as test number, byte address, data; test 0 ends the list
@000
00001537 06400093 FF900113 002081B3 40208233 001122B3 00113333 40115393 // x10 base, add sub slt shifts
01C15413 00409493 0FF0C593 0020E633 0F017693 00508013 00002717 ABCDE7B7 // logic, x0 write, auipc lui
00352023 00452223 00552423 00652623 00752823 00852A23 00952C23 00B52E23 // result stores
02C52023 02D52223 02052423 02E52623 02F52823 00200813 00100893 // stores, branch markers 2 and 1
00108663 05052023 0080006F 05152023 // beq taken
00208663 05052023 0080006F 05152023 // beq not taken
00209663 05052023 0080006F 05152023 // bne taken
00109663 05052023 0080006F 05152023 // bne not taken
00114663 05052023 0080006F 05152023 // blt taken
0020C663 05052023 0080006F 05152023 // blt not taken
0020D663 05052023 0080006F 05152023 // bge taken
00115663 05052023 0080006F 05152023 // bge not taken
0020E663 05052023 0080006F 05152023 // bltu taken
00116663 05052023 0080006F 05152023 // bltu not taken
00117663 05052023 0080006F 05152023 // bgeu taken
0020F663 05052023 0080006F 05152023 // bgeu not taken
0080096F 05052223 05252223 0F5089E7 05052423 05052423 05052423 05352423 // jal, jalr with links
12345A37 678A0A13 05452823 05052A83 05552A23 0000006F // sw, lw, sw again, final jump
@100
00000001 00001000 0000005D
00000001 00001004 0000006B
00000001 00001008 00000001
00000001 0000100C 00000000
00000001 00001010 FFFFFFFC
00000001 00001014 0000000F
00000001 00001018 00000640
00000001 0000101C 0000009B
00000001 00001020 FFFFFFFD
00000001 00001024 000000F0
00000001 00001028 00000000
00000001 0000102C 00002038
00000001 00001030 ABCDE000
00000002 00001040 00000001 00000002 00001040 00000002
00000002 00001040 00000001 00000002 00001040 00000002
00000002 00001040 00000001 00000002 00001040 00000002
00000002 00001040 00000001 00000002 00001040 00000002
00000002 00001040 00000001 00000002 00001040 00000002
00000002 00001040 00000001 00000002 00001040 00000002
00000003 00001044 00000140
00000003 00001048 0000014C
00000004 00001050 12345678
00000004 00001054 12345678
00000000 00000000 00000000

// ==== testbench/tb_rv32_core.sv ====
// Testbench for the RV32I core with a four-phase memory model
// Program image and expected SW records come from testbench/program_patterns.hex,
// run from the project root so the relative path resolves
// Memory is 8 KB, word addressed by mem_addr[12:2]; the program starts at address 0
// Ack is delayed 0 to 3 random cycles; the run ends at the final self-jump
`timescale 1ns/1ps
`default_nettype none

module tb_rv32_core;

	localparam logic [31:0] reset_vector = 32'h0000_0000;
	localparam int mem_words = 2048;
	localparam int prog_words = 256;
	localparam int rec_base = 256;      // First store record in the pattern array
	localparam int run_limit = 20000;   // Cycles for the whole program
	localparam int idle_limit = 200;    // Cycles for any single handshake phase

	logic        clk = 1'b0;
	logic        rst;
	logic        mem_req;
	logic        mem_we;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic        mem_ack;
	logic [31:0] mem_rdata;

	logic [31:0] pat [0:1023];
	logic [31:0] mem [0:mem_words-1];

	int rec_idx;
	int test_errs;
	int hs_errs;
	int pass_count;
	int fail_count;
	bit done;

	logic        prev_req;
	logic        prev_ack;
	logic        prev_we;
	logic [31:0] prev_addr;
	logic [31:0] prev_wdata;

	rv32_core #(
		.RESET_VECTOR(reset_vector)
	) rv32_core_inst (
		.clk       (clk),
		.rst       (rst),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	always #5 clk = ~clk;

	task automatic abort_on_timeout(input string what);
		$display("timeout: %s", what);
		$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic close_test(input int num);
		if (test_errs == 0)
		begin
			pass_count++;
			$display("test %0d passed", num);
		end
		else
		begin
			fail_count++;
			$display("test %0d failed with %0d errors", num, test_errs);
		end
		test_errs = 0;
	endtask

	// Compare one store with the next record, close the test on its last record
	task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
		int tnum;
		tnum = int'(pat[rec_base + 3 * rec_idx]);
		if (tnum == 0)
		begin
			$display("unexpected store of %h to %h after the last record", data, addr);
			fail_count++;
		end
		else
		begin
			if (addr !== pat[rec_base + 3 * rec_idx + 1])
			begin
				$display("mismatch mem_addr test %0d: got %h expected %h",
				         tnum, addr, pat[rec_base + 3 * rec_idx + 1]);
				test_errs++;
			end
			if (data !== pat[rec_base + 3 * rec_idx + 2])
			begin
				$display("mismatch mem_wdata test %0d: got %h expected %h",
				         tnum, data, pat[rec_base + 3 * rec_idx + 2]);
				test_errs++;
			end
			rec_idx++;
			if (int'(pat[rec_base + 3 * rec_idx]) != tnum)
				close_test(tnum);
		end
	endtask

	// Req must not rise over a high ack, and must hold its payload until ack
	// Ack only moves just after a rising edge, so the last negedge sample is what the core saw
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (mem_req && !prev_req && prev_ack)
			begin
				$display("mem_req rose while mem_ack was still high at %0t", $time);
				hs_errs++;
			end
			if (mem_req && prev_req && !prev_ack)
			begin
				if (mem_addr !== prev_addr)
				begin
					$display("mismatch mem_addr: got %h expected %h", mem_addr, prev_addr);
					hs_errs++;
				end
				if (mem_we !== prev_we)
				begin
					$display("mismatch mem_we: got %h expected %h", mem_we, prev_we);
					hs_errs++;
				end
				if (mem_wdata !== prev_wdata)
				begin
					$display("mismatch mem_wdata: got %h expected %h", mem_wdata, prev_wdata);
					hs_errs++;
				end
			end
		end
		prev_req = rst ? 1'b0 : mem_req;
		prev_ack = mem_ack;
		prev_we = mem_we;
		prev_addr = mem_addr;
		prev_wdata = mem_wdata;
	end

	// Memory model, also checks the reset behavior as test 0
	initial
	begin : responder
		int idle;
		int delay;
		int idx;
		bit first_seen;
		void'($urandom(93926));
		first_seen = 0;
		idle = 0;
		do
		begin
			@(negedge clk);
			if (rst && mem_req !== 1'b0)
			begin
				$display("mem_req is high while rst is asserted");
				test_errs++;
			end
			idle++;
			if (idle > run_limit)
				abort_on_timeout("rst never released");
		end
		while (rst);
		forever
		begin
			idle = 0;
			while (!mem_req)
			begin
				@(negedge clk);
				idle++;
				if (idle > idle_limit)
					abort_on_timeout("no memory request from the core");
			end
			if (!first_seen)
			begin
				first_seen = 1;
				if (mem_addr !== reset_vector || mem_we !== 1'b0)
				begin
					$display("first request is not a read at the reset vector: addr %h we %h",
					         mem_addr, mem_we);
					test_errs++;
				end
				close_test(0);
			end
			delay = $urandom_range(3, 0);
			repeat (delay) @(posedge clk);
			@(posedge clk);
			#1;
			idx = int'(mem_addr[12:2]);
			if (mem_we)
			begin
				mem[idx] = mem_wdata;
				check_store(mem_addr, mem_wdata);
			end
			else
			begin
				mem_rdata = mem[idx];
				if (mem[idx] == 32'h0000_006F)   // JAL x0,0 ends the program
					done = 1;
			end
			mem_ack = 1'b1;
			idle = 0;
			do
			begin
				@(negedge clk);
				idle++;
				if (idle > idle_limit)
					abort_on_timeout("mem_req not dropped after mem_ack");
			end
			while (mem_req);
			@(posedge clk);
			#1;
			mem_ack = 1'b0;
		end
	end

	initial
	begin
		int cycles;
		rst = 1'b1;
		mem_ack = 1'b0;
		mem_rdata = '0;
		rec_idx = 0;
		test_errs = 0;
		hs_errs = 0;
		pass_count = 0;
		fail_count = 0;
		done = 0;
		prev_req = 1'b0;
		prev_ack = 1'b0;
		prev_we = 1'b0;
		prev_addr = '0;
		prev_wdata = '0;
		$readmemh("testbench/program_patterns.hex", pat);
		for (int k = 0; k < mem_words; k++)
			mem[k] = 32'hA500_0000 | (32'(k) << 2);
		for (int k = 0; k < prog_words; k++)
			mem[k] = pat[k];

		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		cycles = 0;
		while (!done)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > run_limit)
				abort_on_timeout("program never reached its final jump");
		end
		repeat (4) @(negedge clk);   // Let the last handshake settle

		if (int'(pat[rec_base + 3 * rec_idx]) != 0)
		begin
			$display("store records left unmatched from record %0d on", rec_idx);
			fail_count++;
		end
		if (hs_errs == 0)
		begin
			pass_count++;
			$display("handshake checks passed");
		end
		else
		begin
			fail_count++;
			$display("handshake checks failed with %0d errors", hs_errs);
		end
		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
